// File: common/ooo_pkg.sv
//////////////////////////////////////////////////
// sizes, opcodes and records shared by the core
// the *_W widths are fixed to match the sizes;
// a change to a size needs its width changed too
// any opcode outside the list executes as add
//////////////////////////////////////////////////
`default_nettype none

package ooo_pkg;

  //////////////////////////////////////////////////
  // sizes and widths
  //////////////////////////////////////////////////
  localparam int ARCH_REGS = 8;
  localparam int PHYS_REGS = 16;
  localparam int ROB_DEPTH = 8;
  localparam int RS_DEPTH  = 4;
  localparam int NUM_ALU   = 2;
  localparam int DATA_W    = 32;
  localparam int ARCH_W    = 3;
  localparam int PHYS_W    = 4;
  localparam int ROB_W     = 3;
  localparam int IMM_W     = 14;
  localparam int OP_W      = 3;
  localparam int RS_W      = 2;
  // free list holds the tags beyond the initial mapping
  localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS;
  localparam int FL_W      = 3;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////
  localparam logic [OP_W-1:0] OP_ADD = 3'd0;
  localparam logic [OP_W-1:0] OP_SUB = 3'd1;
  localparam logic [OP_W-1:0] OP_AND = 3'd2;
  localparam logic [OP_W-1:0] OP_OR  = 3'd3;
  localparam logic [OP_W-1:0] OP_XOR = 3'd4;
  // shift amount is the low 5 bits of b
  localparam logic [OP_W-1:0] OP_SHL = 3'd5;

  // operand field, read as register index or immediate
  typedef union packed {
    struct packed {
      logic [ARCH_W-1:0]       src_b;
      logic [IMM_W-ARCH_W-1:0] pad;
    } regs;
    logic [IMM_W-1:0] imm;
  } operand_u;

  // decoded instruction word, 24 bits
  typedef struct packed {
    logic [OP_W-1:0]   opcode;
    logic [ARCH_W-1:0] dest;
    logic [ARCH_W-1:0] src_a;
    logic              imm_form;
    operand_u          operand;
  } inst_t;

  // reservation station slot, also the issue record
  typedef struct packed {
    logic              valid;
    logic [OP_W-1:0]   opcode;
    logic              imm_form;
    logic [IMM_W-1:0]  imm;
    logic [PHYS_W-1:0] src_a_tag;
    logic [PHYS_W-1:0] src_b_tag;
    logic              src_a_ready;
    logic              src_b_ready;
    logic [PHYS_W-1:0] dest_tag;
    logic [ROB_W-1:0]  rob_idx;
  } rs_entry_t;

  // one write on the common data bus
  typedef struct packed {
    logic              valid;
    logic [PHYS_W-1:0] tag;
    logic [DATA_W-1:0] value;
    logic [ROB_W-1:0]  rob_idx;
  } cdb_t;

  // retirement record
  typedef struct packed {
    logic              valid;
    logic [ARCH_W-1:0] dest;
    logic [DATA_W-1:0] value;
  } commit_t;

endpackage

`default_nettype wire

// File: project.f
common/ooo_pkg.sv
rename/map_table.sv
rename/free_list.sv
src/reorder_buffer.sv
src/reservation_station.sv
src/int_alu.sv
src/phys_regfile.sv
src/cdb_arbiter.sv
src/ooo_core.sv
tests/ooo_core_tb.sv

// File: rename/free_list.sv
//////////////////////////////////////////////////
// circular queue of free physical tags
// pop and push may both happen in one cycle
// popping when empty is not guarded here
//////////////////////////////////////////////////
`default_nettype none

module free_list (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       pop,
  input  logic                       push,
  input  logic [ooo_pkg::PHYS_W-1:0] push_tag,
  output logic [ooo_pkg::PHYS_W-1:0] head_tag,
  output logic                       empty
);
  import ooo_pkg::*;

  logic [PHYS_W-1:0] slot_q [FL_DEPTH];
  logic [FL_W-1:0]   head_q;
  logic [FL_W-1:0]   tail_q;
  logic [FL_W:0]     count_q;

  assign head_tag = slot_q[head_q];
  assign empty    = (count_q == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the arch range start free
      for (int i = 0; i < FL_DEPTH; i++) begin
        slot_q[i] <= PHYS_W'(ARCH_REGS + i);
      end
      head_q  <= '0;
      // full queue, so tail wraps onto head
      tail_q  <= '0;
      count_q <= (FL_W+1)'(FL_DEPTH);
    end else begin
      if (push) begin
        slot_q[tail_q] <= push_tag;
        tail_q         <= tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rename/map_table.sv
//////////////////////////////////////////////////
// architectural to physical register map
// lookups are combinational, update on rename_en
// a source equal to dest sees the old mapping
// no checkpoint; there is no recovery path
//////////////////////////////////////////////////
`default_nettype none

module map_table (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       rename_en,
  input  logic [ooo_pkg::ARCH_W-1:0] src_a,
  input  logic [ooo_pkg::ARCH_W-1:0] src_b,
  input  logic [ooo_pkg::ARCH_W-1:0] dest,
  input  logic [ooo_pkg::PHYS_W-1:0] new_tag,
  output logic [ooo_pkg::PHYS_W-1:0] tag_a,
  output logic [ooo_pkg::PHYS_W-1:0] tag_b,
  output logic [ooo_pkg::PHYS_W-1:0] old_tag
);
  import ooo_pkg::*;

  // current mapping, one tag per arch register
  logic [PHYS_W-1:0] map_q [ARCH_REGS];

  // source lookup
  assign tag_a = map_q[src_a];
  assign tag_b = map_q[src_b];
  // previous owner of dest, freed when this one retires
  assign old_tag = map_q[dest];

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map out of reset
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= PHYS_W'(i);
      end
    end else if (rename_en) begin
      map_q[dest] <= new_tag;
    end
  end

endmodule

`default_nettype wire

// File: src/cdb_arbiter.sv
//////////////////////////////////////////////////
// fixed priority bus arbiter, lowest alu first
// purely combinational
//////////////////////////////////////////////////
`default_nettype none

module cdb_arbiter (
  input  ooo_pkg::cdb_t [ooo_pkg::NUM_ALU-1:0] result,
  output logic [ooo_pkg::NUM_ALU-1:0]          grant,
  output ooo_pkg::cdb_t                        cdb
);
  import ooo_pkg::*;

  // scan downward so the lowest valid alu ends up granted
  always_comb begin
    grant = '0;
    cdb   = '0;
    for (int a = NUM_ALU - 1; a >= 0; a--) begin
      if (result[a].valid) begin
        grant    = '0;
        grant[a] = 1'b1;
        cdb      = result[a];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/int_alu.sv
//////////////////////////////////////////////////
// single-cycle integer alu with a result register
// result holds until granted onto the bus
// issue is taken only while ready is high
//////////////////////////////////////////////////
`default_nettype none

module int_alu (
  input  logic                       clock,
  input  logic                       reset,
  input  ooo_pkg::rs_entry_t         issue,
  input  logic [ooo_pkg::DATA_W-1:0] op_a,
  input  logic [ooo_pkg::DATA_W-1:0] op_b_reg,
  input  logic                       grant,
  output logic                       ready,
  output ooo_pkg::cdb_t              result
);
  import ooo_pkg::*;

  logic [DATA_W-1:0] imm_ext;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_out;

  // empty, or emptied at this edge
  assign ready = !result.valid || grant;

  // operand b from register or sign-extended immediate
  assign imm_ext = {{(DATA_W-IMM_W){issue.imm[IMM_W-1]}}, issue.imm};
  assign op_b    = issue.imm_form ? imm_ext : op_b_reg;

  always_comb begin
    case (issue.opcode)
      OP_SUB:  alu_out = op_a - op_b;
      OP_AND:  alu_out = op_a & op_b;
      OP_OR:   alu_out = op_a | op_b;
      OP_XOR:  alu_out = op_a ^ op_b;
      OP_SHL:  alu_out = op_a << op_b[4:0];
      default: alu_out = op_a + op_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (ready) begin
      result.valid   <= issue.valid;
      result.tag     <= issue.dest_tag;
      result.value   <= alu_out;
      result.rob_idx <= issue.rob_idx;
    end
  end

endmodule

`default_nettype wire

// File: src/ooo_core.sv
//////////////////////////////////////////////////
// out-of-order integer core, top level
// input is valid/ready, commit has no back-pressure
// in_ready depends on state only
// up to ROB_DEPTH instructions in flight
//////////////////////////////////////////////////
`default_nettype none

module ooo_core (
  input  logic             clock,
  input  logic             reset,
  input  logic             in_valid,
  input  ooo_pkg::inst_t   in_inst,
  output logic             in_ready,
  output ooo_pkg::commit_t commit
);
  import ooo_pkg::*;

  // rename
  logic [PHYS_W-1:0] tag_a;
  logic [PHYS_W-1:0] tag_b;
  logic [PHYS_W-1:0] old_tag;
  logic [PHYS_W-1:0] new_tag;
  logic              fl_empty;
  // rob
  logic [ROB_W-1:0]  rob_idx;
  logic              rob_full;
  logic [PHYS_W-1:0] free_tag;
  logic              free_en;
  // rs and execute
  logic                      rs_space;
  logic                      accept;
  rs_entry_t                 insert_entry;
  rs_entry_t [NUM_ALU-1:0]   issue;
  logic [NUM_ALU-1:0]        alu_ready;
  logic [NUM_ALU-1:0]        grant;
  cdb_t [NUM_ALU-1:0]        alu_result;
  cdb_t                      cdb;
  // register file
  logic [2*NUM_ALU-1:0][PHYS_W-1:0] rd_tag;
  logic [2*NUM_ALU-1:0][DATA_W-1:0] rd_data;
  logic [1:0][PHYS_W-1:0]           chk_tag;
  logic [1:0]                       chk_ready;

  assign in_ready = !fl_empty && !rob_full && rs_space;
  assign accept   = in_valid && in_ready;

  //////////////////////////////////////////////////
  // dispatch
  //////////////////////////////////////////////////
  map_table map_table_inst (
    .clock(clock), .reset(reset), .rename_en(accept),
    .src_a(in_inst.src_a), .src_b(in_inst.operand.regs.src_b), .dest(in_inst.dest),
    .new_tag(new_tag), .tag_a(tag_a), .tag_b(tag_b), .old_tag(old_tag)
  );

  free_list free_list_inst (
    .clock(clock), .reset(reset), .pop(accept), .push(free_en),
    .push_tag(free_tag), .head_tag(new_tag), .empty(fl_empty)
  );

  reorder_buffer reorder_buffer_inst (
    .clock(clock), .reset(reset), .alloc(accept), .alloc_dest(in_inst.dest),
    .alloc_old_tag(old_tag), .alloc_idx(rob_idx), .full(rob_full), .cdb(cdb),
    .commit(commit), .free_tag(free_tag), .free_en(free_en)
  );

  assign chk_tag[0] = tag_a;
  assign chk_tag[1] = tag_b;

  // immediate form has no second source to wait on
  always_comb begin
    insert_entry.valid       = 1'b1;
    insert_entry.opcode      = in_inst.opcode;
    insert_entry.imm_form    = in_inst.imm_form;
    insert_entry.imm         = in_inst.operand.imm;
    insert_entry.src_a_tag   = tag_a;
    insert_entry.src_b_tag   = tag_b;
    insert_entry.src_a_ready = chk_ready[0];
    insert_entry.src_b_ready = in_inst.imm_form || chk_ready[1];
    insert_entry.dest_tag    = new_tag;
    insert_entry.rob_idx     = rob_idx;
  end

  reservation_station reservation_station_inst (
    .clock(clock), .reset(reset), .insert(accept), .insert_entry(insert_entry),
    .has_space(rs_space), .cdb(cdb), .alu_ready(alu_ready), .issue(issue)
  );

  //////////////////////////////////////////////////
  // execute and complete
  //////////////////////////////////////////////////
  phys_regfile phys_regfile_inst (
    .clock(clock), .reset(reset), .rd_tag(rd_tag), .rd_data(rd_data),
    .chk_tag(chk_tag), .chk_ready(chk_ready), .clear_en(accept),
    .clear_tag(new_tag), .cdb(cdb)
  );

  for (genvar a = 0; a < NUM_ALU; a++) begin : g_alu
    // ports 2a and 2a+1 belong to alu a
    assign rd_tag[2*a]   = issue[a].src_a_tag;
    assign rd_tag[2*a+1] = issue[a].src_b_tag;

    int_alu int_alu_inst (
      .clock(clock), .reset(reset), .issue(issue[a]),
      .op_a(rd_data[2*a]), .op_b_reg(rd_data[2*a+1]), .grant(grant[a]),
      .ready(alu_ready[a]), .result(alu_result[a])
    );
  end

  cdb_arbiter cdb_arbiter_inst (
    .result(alu_result), .grant(grant), .cdb(cdb)
  );

endmodule

`default_nettype wire

// File: src/phys_regfile.sv
//////////////////////////////////////////////////
// physical register values and ready bits
// two read ports per alu, combinational
// one write port from the bus
// ready check sees a same-cycle bus write
//////////////////////////////////////////////////
`default_nettype none

module phys_regfile (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic [2*ooo_pkg::NUM_ALU-1:0][ooo_pkg::PHYS_W-1:0] rd_tag,
  output logic [2*ooo_pkg::NUM_ALU-1:0][ooo_pkg::DATA_W-1:0] rd_data,
  input  logic [1:0][ooo_pkg::PHYS_W-1:0]                   chk_tag,
  output logic [1:0]                                        chk_ready,
  input  logic                                              clear_en,
  input  logic [ooo_pkg::PHYS_W-1:0]                        clear_tag,
  input  ooo_pkg::cdb_t                                     cdb
);
  import ooo_pkg::*;

  logic [DATA_W-1:0]    value_q [PHYS_REGS];
  logic [PHYS_REGS-1:0] ready_q;

  always_comb begin
    for (int p = 0; p < 2 * NUM_ALU; p++) begin
      rd_data[p] = value_q[rd_tag[p]];
    end
    // bus bypass for dispatch
    for (int c = 0; c < 2; c++) begin
      chk_ready[c] = ready_q[chk_tag[c]] || (cdb.valid && cdb.tag == chk_tag[c]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int t = 0; t < PHYS_REGS; t++) begin
        value_q[t] <= '0;
      end
      ready_q <= '1;
    end else begin
      if (cdb.valid) begin
        value_q[cdb.tag] <= cdb.value;
        ready_q[cdb.tag] <= 1'b1;
      end
      // newly allocated dest, never the bus tag
      if (clear_en) begin
        ready_q[clear_tag] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/reorder_buffer.sv
//////////////////////////////////////////////////
// in-order queue of renamed instructions
// allocate at tail, done and value from the bus
// by rob index, retire one head entry per cycle
// commit is a single-cycle pulse, never stalls
//////////////////////////////////////////////////
`default_nettype none

module reorder_buffer (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       alloc,
  input  logic [ooo_pkg::ARCH_W-1:0] alloc_dest,
  input  logic [ooo_pkg::PHYS_W-1:0] alloc_old_tag,
  output logic [ooo_pkg::ROB_W-1:0]  alloc_idx,
  output logic                       full,
  input  ooo_pkg::cdb_t              cdb,
  output ooo_pkg::commit_t           commit,
  output logic [ooo_pkg::PHYS_W-1:0] free_tag,
  output logic                       free_en
);
  import ooo_pkg::*;

  // entry payload
  logic [ARCH_W-1:0] dest_q  [ROB_DEPTH];
  logic [PHYS_W-1:0] old_q   [ROB_DEPTH];
  logic [DATA_W-1:0] value_q [ROB_DEPTH];
  // entry control
  logic [ROB_DEPTH-1:0] done_q;
  logic [ROB_W-1:0]     head_q;
  logic [ROB_W-1:0]     tail_q;
  logic [ROB_W:0]       count_q;
  logic                 retire;

  assign alloc_idx = tail_q;
  assign full      = (count_q == (ROB_W+1)'(ROB_DEPTH));

  //////////////////////////////////////////////////
  // retire from head
  //////////////////////////////////////////////////
  // done is cleared on retire, so an empty rob never retires
  assign retire       = done_q[head_q];
  assign commit.valid = retire;
  assign commit.dest  = dest_q[head_q];
  assign commit.value = value_q[head_q];
  assign free_en      = retire;
  assign free_tag     = old_q[head_q];

  // payload writes
  always_ff @(posedge clock) begin
    if (alloc) begin
      dest_q[tail_q] <= alloc_dest;
      old_q[tail_q]  <= alloc_old_tag;
    end
    if (cdb.valid) begin
      value_q[cdb.rob_idx] <= cdb.value;
    end
  end

  //////////////////////////////////////////////////
  // pointers and done bits
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      // bus never targets the tail or a retiring head
      if (cdb.valid) begin
        done_q[cdb.rob_idx] <= 1'b1;
      end
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      case ({alloc, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/reservation_station.sv
//////////////////////////////////////////////////
// reservation station with bus wakeup
// insert goes to the lowest free slot
// up to one issue per alu, lowest ready slots first
// inserted entries wait at least one cycle
//////////////////////////////////////////////////
`default_nettype none

module reservation_station (
  input  logic                                     clock,
  input  logic                                     reset,
  input  logic                                     insert,
  input  ooo_pkg::rs_entry_t                       insert_entry,
  output logic                                     has_space,
  input  ooo_pkg::cdb_t                            cdb,
  input  logic [ooo_pkg::NUM_ALU-1:0]              alu_ready,
  output ooo_pkg::rs_entry_t [ooo_pkg::NUM_ALU-1:0] issue
);
  import ooo_pkg::*;

  rs_entry_t [RS_DEPTH-1:0] slot_q;
  logic [RS_DEPTH-1:0]      slot_ok;
  logic [RS_DEPTH-1:0]      taken;
  logic [RS_W-1:0]          free_idx;

  // both sources present
  always_comb begin
    for (int s = 0; s < RS_DEPTH; s++) begin
      slot_ok[s] = slot_q[s].valid && slot_q[s].src_a_ready && slot_q[s].src_b_ready;
    end
  end

  // lowest free slot, scanned downward so the lowest wins
  always_comb begin
    free_idx  = '0;
    has_space = 1'b0;
    for (int s = RS_DEPTH - 1; s >= 0; s--) begin
      if (!slot_q[s].valid) begin
        free_idx  = RS_W'(s);
        has_space = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // issue pickers
  //////////////////////////////////////////////////
  // alu 0 takes the lowest ready slot, alu 1 the next one
  always_comb begin
    issue = '0;
    taken = '0;
    for (int a = 0; a < NUM_ALU; a++) begin
      for (int s = 0; s < RS_DEPTH; s++) begin
        if (alu_ready[a] && !issue[a].valid && slot_ok[s] && !taken[s]) begin
          issue[a] = slot_q[s];
          taken[s] = 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // slot state
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      slot_q <= '0;
    end else begin
      for (int s = 0; s < RS_DEPTH; s++) begin
        if (taken[s]) begin
          slot_q[s].valid <= 1'b0;
        end else if (slot_q[s].valid && cdb.valid) begin
          // wakeup on tag match
          if (cdb.tag == slot_q[s].src_a_tag) begin
            slot_q[s].src_a_ready <= 1'b1;
          end
          if (cdb.tag == slot_q[s].src_b_tag) begin
            slot_q[s].src_b_ready <= 1'b1;
          end
        end
      end
      // free slot is never one that issues this cycle
      if (insert) begin
        slot_q[free_idx] <= insert_entry;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/ooo_core_tb.sv
//////////////////////////////////////////////////
// testbench for the out-of-order core
// in-order reference model of the arch registers
// commits are checked at the falling edge
// every wait on the dut has its own cycle limit
//////////////////////////////////////////////////
`default_nettype none

module ooo_core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ooo_pkg::*;

  logic    clock = 1'b0;
  logic    reset;
  logic    in_valid;
  inst_t   in_inst;
  logic    in_ready;
  commit_t commit;

  // reference state and expected commits
  logic [DATA_W-1:0] arch_regs [ARCH_REGS];
  logic [ARCH_W-1:0] exp_dest  [$];
  logic [DATA_W-1:0] exp_value [$];
  logic [ARCH_W-1:0] want_dest;
  logic [DATA_W-1:0] want_value;
  // bookkeeping
  integer seed = 32'h2bc3;
  int     errors = 0;
  int     accepted = 0;
  int     committed = 0;
  logic   timed_out = 1'b0;
  logic   saw_stall = 1'b0;
  logic [31:0] rnd;
  int          gap;

  ooo_core ooo_core_inst (
    .clock(clock), .reset(reset), .in_valid(in_valid), .in_inst(in_inst),
    .in_ready(in_ready), .commit(commit)
  );

  // 100 ns period
  always #50 clock = ~clock;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // one instruction in program order against arch_regs
  function automatic logic [DATA_W-1:0] execute_ref(input inst_t inst);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] r;
    a = arch_regs[inst.src_a];
    // immediate is 14 bits, sign-extended
    if (inst.imm_form) begin
      b = {{(DATA_W-IMM_W){inst.operand[IMM_W-1]}}, inst.operand};
    end else begin
      b = arch_regs[inst.operand[IMM_W-1 -: ARCH_W]];
    end
    case (inst.opcode)
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SHL:  r = a << b[4:0];
      default: r = a + b;
    endcase
    return r;
  endfunction

  function automatic inst_t reg_inst(input logic [2:0] op, input logic [2:0] dest,
                                     input logic [2:0] src_a, input logic [2:0] src_b);
    inst_t inst;
    inst          = '0;
    inst.opcode   = op;
    inst.dest     = dest;
    inst.src_a    = src_a;
    inst.imm_form = 1'b0;
    inst.operand.regs.src_b = src_b;
    return inst;
  endfunction

  function automatic inst_t imm_inst(input logic [2:0] op, input logic [2:0] dest,
                                     input logic [2:0] src_a, input logic [13:0] imm);
    inst_t inst;
    inst             = '0;
    inst.opcode      = op;
    inst.dest        = dest;
    inst.src_a       = src_a;
    inst.imm_form    = 1'b1;
    inst.operand.imm = imm;
    return inst;
  endfunction

  //////////////////////////////////////////////////
  // stimulus tasks, called right after a rising edge
  //////////////////////////////////////////////////
  // hold valid until accepted, then record the expected commit
  task automatic send_inst(input inst_t inst);
    int          waited;
    logic [31:0] value;
    if (!timed_out) begin
      in_valid <= 1'b1;
      in_inst  <= inst;
      waited = 0;
      // in_ready at the falling edge is what the next rising edge sees
      @(negedge clock);
      while (!in_ready && waited < 200) begin
        waited++;
        @(negedge clock);
      end
      if (!in_ready) begin
        $display("%0t ns: in_ready stayed low for 200 cycles, instruction not accepted", $time);
        timed_out = 1'b1;
        in_valid <= 1'b0;
      end else begin
        value = execute_ref(inst);
        arch_regs[inst.dest] = value;
        exp_dest.push_back(inst.dest);
        exp_value.push_back(value);
        accepted++;
      end
      @(posedge clock);
    end
  endtask

  task automatic idle_cycles(input int cycles);
    in_valid <= 1'b0;
    repeat (cycles) @(posedge clock);
  endtask

  // wait until every accepted instruction has committed
  task automatic drain_commits();
    int waited;
    in_valid <= 1'b0;
    waited = 0;
    if (!timed_out) begin
      while (exp_value.size() != 0 && waited < 500) begin
        waited++;
        @(posedge clock);
      end
      if (exp_value.size() != 0) begin
        $display("%0t ns: %0d instructions never committed", $time, exp_value.size());
        timed_out = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // comparison and monitors
  //////////////////////////////////////////////////
  always @(negedge clock) begin
    if (!reset && commit.valid) begin
      committed++;
      if (exp_value.size() == 0) begin
        $display("%0t ns: commit to r%0d with no accepted instruction outstanding",
                 $time, commit.dest);
        errors++;
      end else begin
        want_dest  = exp_dest.pop_front();
        want_value = exp_value.pop_front();
        if (commit.dest !== want_dest) begin
          $display("[FAIL] %0t ns commit.dest got %0d expected %0d",
                   $time, commit.dest, want_dest);
          errors++;
        end
        if (commit.value !== want_value) begin
          $display("[FAIL] %0t ns commit.value got %h expected %h",
                   $time, commit.value, want_value);
          errors++;
        end
      end
    end
    // back-pressure seen while an instruction waits
    if (!reset && in_valid && !in_ready) begin
      saw_stall = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    for (int i = 0; i < ARCH_REGS; i++) begin
      arch_regs[i] = '0;
    end
    reset    = 1'b1;
    in_valid = 1'b0;
    in_inst  = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    // idle after reset
    repeat (4) begin
      @(negedge clock);
      if (commit.valid !== 1'b0) begin
        $display("[FAIL] %0t ns commit.valid got %b expected 0", $time, commit.valid);
        errors++;
      end
      if (in_ready !== 1'b1) begin
        $display("[FAIL] %0t ns in_ready got %b expected 1", $time, in_ready);
        errors++;
      end
    end
    @(posedge clock);

    // dependent register-form chain
    send_inst(imm_inst(OP_ADD, 3'd1, 3'd0, 14'd5));
    send_inst(imm_inst(OP_ADD, 3'd2, 3'd0, 14'd3));
    send_inst(reg_inst(OP_ADD, 3'd3, 3'd1, 3'd2));
    send_inst(reg_inst(OP_SUB, 3'd4, 3'd3, 3'd1));
    send_inst(reg_inst(OP_XOR, 3'd5, 3'd4, 3'd3));
    send_inst(reg_inst(OP_OR, 3'd6, 3'd5, 3'd2));
    send_inst(reg_inst(OP_AND, 3'd7, 3'd6, 3'd3));
    send_inst(reg_inst(OP_SHL, 3'd1, 3'd7, 3'd2));
    // dest equal to both sources
    send_inst(reg_inst(OP_ADD, 3'd1, 3'd1, 3'd1));
    drain_commits();

    // immediates, negative values and shifts
    send_inst(imm_inst(OP_ADD, 3'd2, 3'd0, 14'h3fff));
    send_inst(imm_inst(OP_SUB, 3'd3, 3'd2, 14'h2000));
    send_inst(imm_inst(OP_SHL, 3'd4, 3'd2, 14'd31));
    send_inst(imm_inst(OP_XOR, 3'd5, 3'd1, 14'h1555));
    send_inst(imm_inst(OP_AND, 3'd6, 3'd3, 14'h2aaa));
    send_inst(imm_inst(OP_OR, 3'd7, 3'd0, 14'h1fff));
    // shift amount from the low 5 bits only
    send_inst(imm_inst(OP_SHL, 3'd0, 3'd7, 14'h3fe4));
    drain_commits();

    // random stream, random gaps
    for (int i = 0; i < 300; i++) begin
      rnd = $random(seed);
      send_inst(inst_t'(rnd[23:0]));
      gap = rnd[31:30];
      if (gap != 0) begin
        idle_cycles(gap);
      end
    end
    drain_commits();

    // back-to-back dependent burst
    saw_stall = 1'b0;
    for (int i = 0; i < 40; i++) begin
      send_inst(reg_inst(OP_ADD, 3'd1, 3'd1, 3'd2));
    end
    drain_commits();
    if (!timed_out && !saw_stall) begin
      $display("%0t ns: in_ready never dropped during the burst", $time);
      errors++;
    end
    idle_cycles(5);

    if (!timed_out && accepted != committed) begin
      $display("accepted %0d instructions but saw %0d commits", accepted, committed);
      errors++;
    end
    $display("errors: %0d  accepted: %0d  committed: %0d  timeout: %0d",
             errors, accepted, committed, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
